// File: hdl/integ_pkg.sv
`default_nettype none

package integ_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Register map, byte offsets on the APB side
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_ACCEL    = 8'h04;
    localparam logic [7:0] REG_DT       = 8'h08;
    localparam logic [7:0] REG_SCALE    = 8'h0C;
    localparam logic [7:0] REG_STATUS   = 8'h10;
    localparam logic [7:0] REG_VELOCITY = 8'h14;
    localparam logic [7:0] REG_STEPS    = 8'h18;

    // CTRL bit positions
    localparam int CTRL_START = 0;
    localparam int CTRL_CLEAR = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Bus and core structs
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [7:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // Step operands, held by the register file
    typedef struct packed {
        logic signed [15:0] accel;
        logic [15:0]        dt;
        logic [31:0]        scale;
    } integ_cfg_t;

    typedef struct packed {
        logic signed [31:0] velocity;
        logic [31:0]        steps;
        logic               busy;
    } integ_status_t;

endpackage

`default_nettype wire

// File: hdl/booth_mult.sv
`default_nettype none

module booth_mult #(
    parameter int MUL_W = 16
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      go,
    input  logic signed [MUL_W-1:0]   multiplicand,
    input  logic [MUL_W-1:0]          multiplier,
    output logic                      done,
    output logic signed [2*MUL_W-1:0] product
);

    localparam int CNT_W = $clog2(MUL_W + 1);

    // One guard bit on the partial product so that subtracting
    // the most negative multiplicand cannot overflow
    logic signed [MUL_W:0] mcand;
    logic signed [MUL_W:0] acc;
    logic [MUL_W-1:0]      q;
    logic                  q_m1;
    logic [CNT_W-1:0]      count;
    logic                  running;
    logic                  last;

    logic signed [MUL_W:0] sum;
    logic signed [MUL_W:0] acc_next;
    logic [MUL_W-1:0]      q_next;
    logic [MUL_W-1:0]      upper;

    always_comb begin
        last = (count == CNT_W'(MUL_W - 1));

        // Booth pair {q0, q-1}
        case ({q[0], q_m1})
            2'b01:   sum = acc + mcand;
            2'b10:   sum = acc - mcand;
            default: sum = acc;
        endcase
        acc_next = sum >>> 1;
        q_next   = {sum[0], q[MUL_W-1:1]};

        // Multiplier is really MUL_W+1 bits with a zero on top, so the
        // final pair is {0, msb}: add the multiplicand once more, no shift
        if (q[0]) begin
            upper = acc_next[MUL_W-1:0] + mcand[MUL_W-1:0];
        end else begin
            upper = acc_next[MUL_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (go) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (last) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (go) begin
            mcand <= {multiplicand[MUL_W-1], multiplicand};
            acc   <= '0;
            q     <= multiplier;
            q_m1  <= 1'b0;
        end else if (running) begin
            acc  <= acc_next;
            q    <= q_next;
            q_m1 <= q[0];
            if (last) begin
                product <= {upper, q_next};
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/seq_div.sv
`default_nettype none

module seq_div #(
    parameter int ACC_W = 48
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             go,
    input  logic [ACC_W-1:0] dividend,
    input  logic [31:0]      divisor,
    output logic             done,
    output logic [ACC_W-1:0] quotient,
    output logic [31:0]      remainder
);

    localparam int CNT_W = $clog2(ACC_W + 1);

    logic [ACC_W-1:0] q;
    logic [31:0]      r;
    logic [31:0]      dvsr;
    logic             dvsr_zero;
    logic [CNT_W-1:0] count;
    logic             running;
    logic             last;

    logic [32:0]      shifted;
    logic [33:0]      diff;
    logic             fits;
    logic [31:0]      r_next;
    logic [ACC_W-1:0] q_next;

    // One restoring step, next dividend bit shifted into the remainder
    always_comb begin
        last    = (count == CNT_W'(ACC_W - 1));
        shifted = {r, q[ACC_W-1]};
        diff    = {1'b0, shifted} - {2'b00, dvsr};
        fits    = ~diff[33];
        if (fits) begin
            r_next = diff[31:0];
        end else begin
            r_next = shifted[31:0];
        end
        q_next = {q[ACC_W-2:0], fits};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            done    <= 1'b0;
            count   <= '0;
        end else begin
            done <= 1'b0;
            if (go) begin
                running <= 1'b1;
                count   <= '0;
            end else if (running) begin
                count <= count + 1'b1;
                if (last) begin
                    running <= 1'b0;
                    done    <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            q         <= dividend;
            r         <= '0;
            dvsr      <= divisor;
            dvsr_zero <= (divisor == 32'd0);
        end else if (running) begin
            q <= q_next;
            r <= r_next;
            if (last) begin
                // Division by zero saturates the quotient
                quotient  <= dvsr_zero ? '1 : q_next;
                remainder <= r_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/velocity_integrator.sv
`default_nettype none

module velocity_integrator #(
    parameter int MUL_W = 16,
    parameter int ACC_W = 48
) (
    input  logic                     clk,
    input  logic                     rst,
    input  integ_pkg::integ_cfg_t    cfg,
    input  logic                     start,
    input  logic                     clear,
    output integ_pkg::integ_status_t status
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_MUL,
        S_ACC,
        S_DIV,
        S_FIN
    } state_t;

    state_t state;

    logic signed [ACC_W-1:0] acc;
    logic signed [31:0]      velocity;
    logic [31:0]             steps;
    logic [31:0]             quot_lo;

    logic                      mul_done;
    logic signed [2*MUL_W-1:0] product;
    logic                      div_go;
    logic                      div_done;
    logic                      acc_neg;
    logic [ACC_W-1:0]          acc_mag;
    logic [ACC_W-1:0]          quotient;

    ////////////////////////////////////////////////////////////////////////////
    // Arithmetic units
    ////////////////////////////////////////////////////////////////////////////

    // Multiply starts on the start pulse itself, operands sampled there
    booth_mult #(
        .MUL_W(MUL_W)
    ) u_mult (
        .clk         (clk),
        .rst         (rst),
        .go          (start),
        .multiplicand(cfg.accel),
        .multiplier  (cfg.dt),
        .done        (mul_done),
        .product     (product)
    );

    // Divide magnitude only, sign restored in S_FIN
    always_comb begin
        acc_neg = acc[ACC_W-1];
        acc_mag = acc_neg ? -acc : acc;
        div_go  = (state == S_ACC);
    end

    seq_div #(
        .ACC_W(ACC_W)
    ) u_div (
        .clk      (clk),
        .rst      (rst),
        .go       (div_go),
        .dividend (acc_mag),
        .divisor  (cfg.scale),
        .done     (div_done),
        .quotient (quotient),
        .remainder()
    );

    ////////////////////////////////////////////////////////////////////////////
    // Step sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            acc      <= '0;
            velocity <= '0;
            steps    <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // Clear lands on the same edge, step then runs from zero
                    if (clear) begin
                        acc      <= '0;
                        velocity <= '0;
                        steps    <= '0;
                    end
                    if (start) begin
                        state <= S_MUL;
                    end
                end
                S_MUL: begin
                    if (mul_done) begin
                        acc   <= acc + {{(ACC_W - 2*MUL_W){product[2*MUL_W-1]}}, product};
                        state <= S_ACC;
                    end
                end
                S_ACC: begin
                    state <= S_DIV;
                end
                S_DIV: begin
                    if (div_done) begin
                        state <= S_FIN;
                    end
                end
                S_FIN: begin
                    velocity <= acc_neg ? -quot_lo : quot_lo;
                    steps    <= steps + 32'd1;
                    state    <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Low word of the quotient, velocity keeps 32 bits only
    always_ff @(posedge clk) begin
        if (state == S_DIV && div_done) begin
            quot_lo <= quotient[31:0];
        end
    end

    always_comb begin
        status.velocity = velocity;
        status.steps    = steps;
        status.busy     = (state != S_IDLE);
    end

endmodule

`default_nettype wire

// File: hdl/integ_apb_regs.sv
`default_nettype none

module integ_apb_regs (
    input  logic                     clk,
    input  logic                     rst,
    input  integ_pkg::apb_req_t      apb_req,
    output integ_pkg::apb_rsp_t      apb_rsp,
    input  integ_pkg::integ_status_t status,
    output integ_pkg::integ_cfg_t    cfg,
    output logic                     start,
    output logic                     clear
);

    import integ_pkg::*;

    logic        access;
    logic        err;
    logic        wr_ok;
    logic [31:0] rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        access = apb_req.psel && apb_req.penable;
        err    = 1'b0;
        rdata  = '0;
        case (apb_req.paddr)
            REG_CTRL: begin
                // Write only, refused while a step runs
                err = apb_req.pwrite && status.busy;
            end
            REG_ACCEL: begin
                rdata = {16'h0000, cfg.accel};
            end
            REG_DT: begin
                rdata = {16'h0000, cfg.dt};
            end
            REG_SCALE: begin
                rdata = cfg.scale;
            end
            REG_STATUS: begin
                rdata = {31'd0, status.busy};
                err   = apb_req.pwrite;
            end
            REG_VELOCITY: begin
                rdata = status.velocity;
                err   = apb_req.pwrite;
            end
            REG_STEPS: begin
                rdata = status.steps;
                err   = apb_req.pwrite;
            end
            default: begin
                err = 1'b1;
            end
        endcase

        wr_ok = access && apb_req.pwrite && !err;

        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access && err;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Config registers and control pulses
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.accel <= '0;
            cfg.dt    <= '0;
            cfg.scale <= 32'd1;
            start     <= 1'b0;
            clear     <= 1'b0;
        end else begin
            start <= 1'b0;
            clear <= 1'b0;
            if (wr_ok) begin
                case (apb_req.paddr)
                    REG_CTRL: begin
                        start <= apb_req.pwdata[CTRL_START];
                        clear <= apb_req.pwdata[CTRL_CLEAR];
                    end
                    REG_ACCEL: cfg.accel <= apb_req.pwdata[15:0];
                    REG_DT:    cfg.dt    <= apb_req.pwdata[15:0];
                    REG_SCALE: cfg.scale <= apb_req.pwdata;
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/integ_top.sv
`default_nettype none

module integ_top #(
    parameter int MUL_W = 16,
    parameter int ACC_W = 48
) (
    input  logic                clk,
    input  logic                rst,
    input  integ_pkg::apb_req_t apb_req,
    output integ_pkg::apb_rsp_t apb_rsp
);

    import integ_pkg::*;

    integ_cfg_t    cfg;
    integ_status_t status;
    logic          start;
    logic          clear;

    // Host side
    integ_apb_regs u_regs (
        .clk    (clk),
        .rst    (rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp),
        .status (status),
        .cfg    (cfg),
        .start  (start),
        .clear  (clear)
    );

    // Core, one step at a time
    velocity_integrator #(
        .MUL_W(MUL_W),
        .ACC_W(ACC_W)
    ) u_integ (
        .clk   (clk),
        .rst   (rst),
        .cfg   (cfg),
        .start (start),
        .clear (clear),
        .status(status)
    );

endmodule

`default_nettype wire

// File: test/integ_tb.sv
`default_nettype none

module integ_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import integ_pkg::*;

    localparam string STIM_FILE = "test/integ_stimulus.txt";
    localparam int    POLL_MAX  = 500;
    localparam int    LINE_MAX  = 10000;

    logic     clk;
    logic     rst;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    int unsigned lcg_state;
    int          n_checks;
    int          n_errors;
    int          n_tests;
    int          n_failed;
    int          test_errs;
    bit          aborted;

    integ_top DUT (
        .clk    (clk),
        .rst    (rst),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus helpers
    ////////////////////////////////////////////////////////////////////////////

    // LCG step with the classic constants
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic apb_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic slverr,
                                output logic ready);
        int gap;
        // Upper LCG bits pick the idle gap
        gap = int'((next_rand() >> 16) & 32'd3);
        repeat (gap) @(posedge clk);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.pwrite  <= wr;
        apb_req.pwdata  <= wdata;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // Response is settled by the falling edge of the access cycle
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        ready  = apb_rsp.pready;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic check_xfer(input logic wr, input logic [7:0] addr,
                              input logic [31:0] data, input logic exp_err);
        logic [31:0] rdata;
        logic        slverr;
        logic        ready;
        apb_transfer(wr, addr, data, rdata, slverr, ready);
        n_checks++;
        assert (ready === 1'b1) else begin
            $display("ERR t=%0t ns addr 0x%02h: pready expected 1 got %0b",
                     $time, addr, ready);
            n_errors++;
            test_errs++;
        end
        n_checks++;
        assert (slverr === exp_err) else begin
            $display("ERR t=%0t ns addr 0x%02h: pslverr expected %0b got %0b",
                     $time, addr, exp_err, slverr);
            n_errors++;
            test_errs++;
        end
        if (!wr) begin
            n_checks++;
            assert (rdata === data) else begin
                $display("ERR t=%0t ns addr 0x%02h: prdata expected %08h got %08h",
                         $time, addr, data, rdata);
                n_errors++;
                test_errs++;
            end
        end
    endtask

    // Poll STATUS until the step is over
    task automatic wait_idle();
        logic [31:0] rdata;
        logic        slverr;
        logic        ready;
        int          polls;
        polls = 0;
        rdata = 32'd1;
        while (rdata[0] !== 1'b0 && polls < POLL_MAX) begin
            apb_transfer(1'b0, REG_STATUS, 32'd0, rdata, slverr, ready);
            polls++;
        end
        if (rdata[0] !== 1'b0) begin
            $display("Timeout: busy still set after %0d STATUS polls at %0t ns",
                     POLL_MAX, $time);
            n_errors++;
            test_errs++;
            aborted = 1'b1;
        end
    endtask

    task automatic close_test(input string name);
        n_tests++;
        if (test_errs == 0) begin
            $display("test %0s: ok", name);
        end else begin
            n_failed++;
            $display("test %0s: %0d error(s)", name, test_errs);
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence, driven by the stimulus file
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n_lines;
        int          n_fields;
        string       line;
        string       name;
        logic [7:0]  op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] err;

        lcg_state = 32'd64;
        n_checks  = 0;
        n_errors  = 0;
        n_tests   = 0;
        n_failed  = 0;
        test_errs = 0;
        aborted   = 1'b0;
        rst     <= 1'b1;
        apb_req <= '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %0s", STIM_FILE);
            aborted = 1'b1;
        end
        n_lines = 0;
        while (!aborted && n_lines < LINE_MAX && $fgets(line, fd) > 0) begin
            n_lines++;
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            op = line[0];
            case (op)
                "W", "R": begin
                    n_fields = $sscanf(line, "%c %h %h %h", op, addr, data, err);
                    if (n_fields != 4) begin
                        $display("Stimulus line %0d could not be parsed", n_lines);
                        n_errors++;
                        test_errs++;
                    end else begin
                        check_xfer(op == "W", addr[7:0], data, err[0]);
                    end
                end
                "P": wait_idle();
                "T": begin
                    n_fields = $sscanf(line, "%c %s", op, name);
                    close_test(name);
                end
                default: begin
                    $display("Stimulus line %0d has an unknown opcode", n_lines);
                    n_errors++;
                    test_errs++;
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        // Errors after the last marker still count as a test
        if (test_errs != 0) begin
            close_test("unnamed");
        end

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 n_tests, n_failed, n_checks, n_errors);
        if (n_errors == 0 && !aborted && n_tests > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: integrator.f
hdl/integ_pkg.sv
hdl/booth_mult.sv
hdl/seq_div.sv
hdl/velocity_integrator.sv
hdl/integ_apb_regs.sv
hdl/integ_top.sv
test/integ_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= integ_tb
FILELIST  ?= integrator.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
STIM      ?= test/integ_stimulus.txt
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN) $(STIM)
	$(BIN) | tee $(LOG)
	@grep -q '^PASS: all tests$$' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

check:
	@grep -q '^PASS: all tests$$' $(LOG) || (echo "no pass found in $(LOG)"; exit 1)
	@echo "$(LOG) reports a pass"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/integ_stimulus.txt
# Columns: op addr data err, all hex. W writes data, R expects data as read data.
# err is the expected PSLVERR. P polls STATUS until idle. T name closes a test.
R 0C 00000001 0
R 10 00000000 0
R 14 00000000 0
R 18 00000000 0
R 04 00000000 0
W 04 0000ABCD 0
R 04 0000ABCD 0
W 08 00001234 0
R 08 00001234 0
W 0C 12345678 0
R 0C 12345678 0
T reset_readback
W 04 0000012C 0
W 08 00000014 0
W 0C 00000007 0
W 00 00000001 0
P
R 14 00000359 0
R 18 00000001 0
R 10 00000000 0
T single_step
W 04 0000FE0C 0
W 00 00000001 0
P
R 14 FFFFFDC5 0
W 04 0000FC18 0
W 08 00000003 0
W 00 00000001 0
P
R 14 FFFFFC18 0
W 04 000004D2 0
W 08 00000005 0
W 00 00000001 0
P
R 14 FFFFFF8A 0
W 04 00008000 0
W 08 0000FFFF 0
W 00 00000001 0
P
R 14 EDB6ED41 0
W 04 00007FFF 0
W 00 00000001 0
P
R 14 FFFFDAF8 0
R 18 00000006 0
T accumulate
W 00 00000002 0
R 14 00000000 0
R 18 00000000 0
W 00 00000001 0
P
R 14 1248EDB7 0
W 04 0000FED4 0
W 08 00000014 0
W 00 00000003 0
P
R 14 FFFFFCA7 0
R 18 00000001 0
T clear
W 00 00000002 0
W 04 00000064 0
W 08 0000000A 0
W 0C 00000000 0
W 00 00000001 0
P
R 14 FFFFFFFF 0
T zero_scale
R 40 00000000 1
W 1C 00000000 1
W 14 12345678 1
W 10 00000001 1
R 14 FFFFFFFF 0
W 0C 00000007 0
W 00 00000002 0
W 04 0000012C 0
W 08 00000014 0
W 00 00000001 0
W 00 00000001 1
W 00 00000002 1
P
R 14 00000359 0
R 18 00000001 0
T error_responses
